// ==== rtl/drizzle_cfg.svh ====
`ifndef DRIZZLE_CFG_SVH
`define DRIZZLE_CFG_SVH

// payload bits of one flit, not counting the last bit
`define DRZ_FLIT_W 10

// entries in each router input FIFO
`define DRZ_FIFO_DEPTH 4

// node id of the first node in the chain, the next node takes the following id
`define DRZ_FIRST_ID 1

`endif

// ==== rtl/drizzle_pkg.sv ====
`default_nettype none

`include "drizzle_cfg.svh"

package drizzle_pkg;

  // node number carried in the header flit
  typedef logic [3:0] node_id_t;

  // payload of the first flit of a packet
  typedef struct packed {
    node_id_t   dest;
    node_id_t   src;
    logic [1:0] tag;
  } flit_hdr_t;

  // the same payload bits seen as a header or as raw data
  typedef union packed {
    flit_hdr_t                 hdr;
    logic [`DRZ_FLIT_W-1:0]    raw;
  } flit_body_u;

  // one flit on a link, last marks the end of the packet
  typedef struct packed {
    logic       last;
    flit_body_u body;
  } flit_t;

  // the three ports of a node, also used as indices into port masks
  typedef enum logic [1:0] {
    port_top   = 2'd0,
    port_bot   = 2'd1,
    port_local = 2'd2
  } port_sel_t;

  // one bit per port, indexed by port_sel_t
  typedef logic [2:0] port_mask_t;

endpackage

`default_nettype wire

// ==== rtl/flit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drizzle_cfg.svh"

module flit_fifo (
  input  logic               BD_in_clk,
  input  logic               reset,
  input  drizzle_pkg::flit_t in_data,
  input  logic               in_valid,
  output logic               in_ready,
  output drizzle_pkg::flit_t out_data,
  output logic               out_valid,
  input  logic               pop
);
  import drizzle_pkg::*;

  localparam int DEPTH = `DRZ_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             do_pop;

  // pointers wrap at DEPTH so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push      = in_valid && in_ready;
  assign do_pop    = pop && out_valid;
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  always_comb begin
    count_next = count;
    if (push && !do_pop) begin
      count_next = count + 1'b1;
    end else if (do_pop && !push) begin
      count_next = count - 1'b1;
    end
  end

  // ready is registered from the next count, so it is low during reset
  always_ff @(posedge BD_in_clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count    <= count_next;
      in_ready <= (count_next != CNT_W'(DEPTH));
    end
  end

  always_ff @(posedge BD_in_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/port_input.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_input #(
  parameter drizzle_pkg::node_id_t NODE_ID = drizzle_pkg::node_id_t'(0)
) (
  input  logic                   BD_in_clk,
  input  logic                   reset,
  input  drizzle_pkg::flit_t     link_data,
  input  logic                   link_valid,
  output logic                   link_ready,
  output drizzle_pkg::flit_t     head_data,
  output drizzle_pkg::port_mask_t request,
  input  logic                   grant,
  input  logic                   out_ready
);
  import drizzle_pkg::*;

  flit_t      fifo_data;
  logic       fifo_valid;
  logic       pop;
  logic       in_packet;
  port_mask_t route_dec;
  port_mask_t route_q;
  port_mask_t route;

  flit_fifo u_fifo (
    .BD_in_clk (BD_in_clk),
    .reset     (reset),
    .in_data   (link_data),
    .in_valid  (link_valid),
    .in_ready  (link_ready),
    .out_data  (fifo_data),
    .out_valid (fifo_valid),
    .pop       (pop)
  );

  assign head_data = fifo_data;

  // route of a header flit, only meaningful while no packet is in progress
  always_comb begin
    route_dec = '0;
    if (fifo_data.body.hdr.dest == NODE_ID) begin
      route_dec[port_local] = 1'b1;
    end else if (fifo_data.body.hdr.dest > NODE_ID) begin
      route_dec[port_bot] = 1'b1;
    end else begin
      route_dec[port_top] = 1'b1;
    end
  end

  // body flits follow the route stored from their header
  assign route   = in_packet ? route_q : route_dec;
  assign request = fifo_valid ? route : '0;

  // out_ready is the ready of the output this input points at
  assign pop = fifo_valid && grant && out_ready;

  always_ff @(posedge BD_in_clk) begin
    if (reset) begin
      in_packet <= 1'b0;
    end else if (pop) begin
      in_packet <= !fifo_data.last;
    end
  end

  always_ff @(posedge BD_in_clk) begin
    if (pop && !in_packet) begin
      route_q <= route_dec;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/port_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
  input  logic                    BD_in_clk,
  input  logic                    reset,
  input  drizzle_pkg::port_mask_t requests,
  input  drizzle_pkg::flit_t      head_data [3],
  output drizzle_pkg::port_mask_t grant,
  output drizzle_pkg::flit_t      link_data,
  output logic                    link_valid,
  input  logic                    link_ready
);
  import drizzle_pkg::*;

  logic       busy_q;
  port_mask_t grant_q;
  port_sel_t  last_q;
  port_mask_t pick;
  port_sel_t  pick_sel;
  logic       found;
  logic [1:0] cand;
  logic       xfer_last;

  // search starts just past the last winner and wraps over the three inputs
  always_comb begin
    pick     = '0;
    pick_sel = last_q;
    found    = 1'b0;
    cand     = '0;
    for (int k = 1; k <= 3; k++) begin
      cand = 2'((int'(last_q) + k) % 3);
      if (!found && requests[cand]) begin
        found       = 1'b1;
        pick[cand]  = 1'b1;
        pick_sel    = port_sel_t'(cand);
      end
    end
  end

  // while idle the fresh pick is shown at once, then it is held in grant_q
  assign grant      = busy_q ? grant_q : pick;
  assign link_valid = |(grant & requests);
  assign xfer_last  = link_valid && link_ready && link_data.last;

  always_comb begin
    link_data = '0;
    for (int i = 0; i < 3; i++) begin
      if (grant[i]) begin
        link_data = head_data[i];
      end
    end
  end

  always_ff @(posedge BD_in_clk) begin
    if (reset) begin
      busy_q  <= 1'b0;
      grant_q <= '0;
      last_q  <= port_local;
    end else if (busy_q) begin
      if (xfer_last) begin
        busy_q  <= 1'b0;
        grant_q <= '0;
      end
    end else if (found) begin
      last_q <= pick_sel;
      // a one-flit packet that leaves right away never locks the output
      if (!xfer_last) begin
        busy_q  <= 1'b1;
        grant_q <= pick;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/drizzle_node.sv ====
`timescale 1ns/1ps
`default_nettype none

module drizzle_node #(
  parameter drizzle_pkg::node_id_t NODE_ID = drizzle_pkg::node_id_t'(0)
) (
  input  logic               BD_in_clk,
  input  logic               reset,
  input  drizzle_pkg::flit_t top_in_data,
  input  logic               top_in_valid,
  output logic               top_in_ready,
  output drizzle_pkg::flit_t top_out_data,
  output logic               top_out_valid,
  input  logic               top_out_ready,
  input  drizzle_pkg::flit_t bot_in_data,
  input  logic               bot_in_valid,
  output logic               bot_in_ready,
  output drizzle_pkg::flit_t bot_out_data,
  output logic               bot_out_valid,
  input  logic               bot_out_ready,
  input  drizzle_pkg::flit_t local_in_data,
  input  logic               local_in_valid,
  output logic               local_in_ready,
  output drizzle_pkg::flit_t local_out_data,
  output logic               local_out_valid,
  input  logic               local_out_ready
);
  import drizzle_pkg::*;

  // per-port signals, indexed by port_sel_t
  flit_t      in_data_a  [3];
  flit_t      out_data_a [3];
  flit_t      head_a     [3];
  port_mask_t req_a      [3];
  port_mask_t arb_req    [3];
  port_mask_t arb_grant  [3];
  logic [2:0] in_valid_a;
  logic [2:0] in_ready_a;
  logic [2:0] out_valid_a;
  logic [2:0] out_ready_a;
  logic [2:0] in_grant;
  logic [2:0] in_out_ready;

  // the enum order is top, bot, local
  assign in_data_a[0] = top_in_data;
  assign in_data_a[1] = bot_in_data;
  assign in_data_a[2] = local_in_data;
  assign in_valid_a   = {local_in_valid, bot_in_valid, top_in_valid};
  assign out_ready_a  = {local_out_ready, bot_out_ready, top_out_ready};

  assign top_in_ready    = in_ready_a[port_top];
  assign bot_in_ready    = in_ready_a[port_bot];
  assign local_in_ready  = in_ready_a[port_local];
  assign top_out_data    = out_data_a[port_top];
  assign bot_out_data    = out_data_a[port_bot];
  assign local_out_data  = out_data_a[port_local];
  assign top_out_valid   = out_valid_a[port_top];
  assign bot_out_valid   = out_valid_a[port_bot];
  assign local_out_valid = out_valid_a[port_local];

  // request bit o of input i goes to bit i of output o's arbiter
  always_comb begin
    for (int o = 0; o < 3; o++) begin
      for (int i = 0; i < 3; i++) begin
        arb_req[o][i] = req_a[i][o];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      in_grant[i]     = 1'b0;
      in_out_ready[i] = |(req_a[i] & out_ready_a);
      for (int o = 0; o < 3; o++) begin
        in_grant[i] = in_grant[i] | arb_grant[o][i];
      end
    end
  end

  for (genvar g = 0; g < 3; g++) begin : gen_port
    port_input #(
      .NODE_ID (NODE_ID)
    ) u_in (
      .BD_in_clk  (BD_in_clk),
      .reset      (reset),
      .link_data  (in_data_a[g]),
      .link_valid (in_valid_a[g]),
      .link_ready (in_ready_a[g]),
      .head_data  (head_a[g]),
      .request    (req_a[g]),
      .grant      (in_grant[g]),
      .out_ready  (in_out_ready[g])
    );

    port_arbiter u_out (
      .BD_in_clk  (BD_in_clk),
      .reset      (reset),
      .requests   (arb_req[g]),
      .head_data  (head_a),
      .grant      (arb_grant[g]),
      .link_data  (out_data_a[g]),
      .link_valid (out_valid_a[g]),
      .link_ready (out_ready_a[g])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/drizzle_chain.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drizzle_cfg.svh"

module drizzle_chain (
  input  logic               BD_in_clk,
  input  logic               reset,
  input  drizzle_pkg::flit_t top_in_data,
  input  logic               top_in_valid,
  output logic               top_in_ready,
  output drizzle_pkg::flit_t top_out_data,
  output logic               top_out_valid,
  input  logic               top_out_ready,
  input  drizzle_pkg::flit_t n0_local_in_data,
  input  logic               n0_local_in_valid,
  output logic               n0_local_in_ready,
  output drizzle_pkg::flit_t n0_local_out_data,
  output logic               n0_local_out_valid,
  input  logic               n0_local_out_ready,
  input  drizzle_pkg::flit_t n1_local_in_data,
  input  logic               n1_local_in_valid,
  output logic               n1_local_in_ready,
  output drizzle_pkg::flit_t n1_local_out_data,
  output logic               n1_local_out_valid,
  input  logic               n1_local_out_ready,
  input  drizzle_pkg::flit_t bot_in_data,
  input  logic               bot_in_valid,
  output logic               bot_in_ready,
  output drizzle_pkg::flit_t bot_out_data,
  output logic               bot_out_valid,
  input  logic               bot_out_ready
);
  import drizzle_pkg::*;

  // downward link from node 0 bot to node 1 top
  flit_t dn_data;
  logic  dn_valid;
  logic  dn_ready;

  // upward link from node 1 top back to node 0 bot
  flit_t up_data;
  logic  up_valid;
  logic  up_ready;

  drizzle_node #(
    .NODE_ID (node_id_t'(`DRZ_FIRST_ID))
  ) u_node0 (
    .BD_in_clk       (BD_in_clk),
    .reset           (reset),
    .top_in_data     (top_in_data),
    .top_in_valid    (top_in_valid),
    .top_in_ready    (top_in_ready),
    .top_out_data    (top_out_data),
    .top_out_valid   (top_out_valid),
    .top_out_ready   (top_out_ready),
    .bot_in_data     (up_data),
    .bot_in_valid    (up_valid),
    .bot_in_ready    (up_ready),
    .bot_out_data    (dn_data),
    .bot_out_valid   (dn_valid),
    .bot_out_ready   (dn_ready),
    .local_in_data   (n0_local_in_data),
    .local_in_valid  (n0_local_in_valid),
    .local_in_ready  (n0_local_in_ready),
    .local_out_data  (n0_local_out_data),
    .local_out_valid (n0_local_out_valid),
    .local_out_ready (n0_local_out_ready)
  );

  drizzle_node #(
    .NODE_ID (node_id_t'(`DRZ_FIRST_ID + 1))
  ) u_node1 (
    .BD_in_clk       (BD_in_clk),
    .reset           (reset),
    .top_in_data     (dn_data),
    .top_in_valid    (dn_valid),
    .top_in_ready    (dn_ready),
    .top_out_data    (up_data),
    .top_out_valid   (up_valid),
    .top_out_ready   (up_ready),
    .bot_in_data     (bot_in_data),
    .bot_in_valid    (bot_in_valid),
    .bot_in_ready    (bot_in_ready),
    .bot_out_data    (bot_out_data),
    .bot_out_valid   (bot_out_valid),
    .bot_out_ready   (bot_out_ready),
    .local_in_data   (n1_local_in_data),
    .local_in_valid  (n1_local_in_valid),
    .local_in_ready  (n1_local_in_ready),
    .local_out_data  (n1_local_out_data),
    .local_out_valid (n1_local_out_valid),
    .local_out_ready (n1_local_out_ready)
  );

endmodule

`default_nettype wire

// ==== bench/drizzle_chain_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drizzle_cfg.svh"

module drizzle_chain_tb;
  import drizzle_pkg::*;

  localparam int NPORT = 4;
  localparam int NPKT = 40;
  localparam int MAX_LEN = 6;
  localparam int SEND_LIMIT = NPORT * NPKT * MAX_LEN * 4;
  localparam int DRAIN_LIMIT = 500;
  localparam int QUIET_CYCLES = 20;

  // external ports are numbered top, n0 local, n1 local, bot, and that number is the source code
  logic        BD_in_clk = 1'b0;
  logic        reset;
  flit_t       in_data [NPORT];
  logic [3:0]  in_valid;
  logic [3:0]  in_ready;
  flit_t       out_data [NPORT];
  logic [3:0]  out_valid;
  logic [3:0]  out_ready;

  flit_t       send_q [NPORT][$];
  // expected flits per output and source, at index out * NPORT + src
  flit_t       exp_q [NPORT*NPORT][$];
  int          sent_idx [NPORT];
  logic [3:0]  in_fire;
  logic [31:0] rng_state;
  logic [3:0]  in_pkt;
  int          cur_src [NPORT];
  logic [1:0]  cur_tag [NPORT];
  int          checks [1:5];
  int          fails [1:5];
  // packet counts for local delivery, top to bot and bot to top
  int          pkts_exp [3];
  int          pkts_got [3];
  int          flits_sent;
  int          flits_got;
  int          cycles;
  int          drain_cycles;
  int          quiet;
  int          total_errors;
  logic        timed_out;

  always #5 BD_in_clk = ~BD_in_clk;

  drizzle_chain uut (
    .BD_in_clk          (BD_in_clk),
    .reset              (reset),
    .top_in_data        (in_data[0]),
    .top_in_valid       (in_valid[0]),
    .top_in_ready       (in_ready[0]),
    .top_out_data       (out_data[0]),
    .top_out_valid      (out_valid[0]),
    .top_out_ready      (out_ready[0]),
    .n0_local_in_data   (in_data[1]),
    .n0_local_in_valid  (in_valid[1]),
    .n0_local_in_ready  (in_ready[1]),
    .n0_local_out_data  (out_data[1]),
    .n0_local_out_valid (out_valid[1]),
    .n0_local_out_ready (out_ready[1]),
    .n1_local_in_data   (in_data[2]),
    .n1_local_in_valid  (in_valid[2]),
    .n1_local_in_ready  (in_ready[2]),
    .n1_local_out_data  (out_data[2]),
    .n1_local_out_valid (out_valid[2]),
    .n1_local_out_ready (out_ready[2]),
    .bot_in_data        (in_data[3]),
    .bot_in_valid       (in_valid[3]),
    .bot_in_ready       (in_ready[3]),
    .bot_out_data       (out_data[3]),
    .bot_out_valid      (out_valid[3]),
    .bot_out_ready      (out_ready[3])
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // a packet climbs to a smaller id, sinks to a larger one and leaves locally when ids match,
  // so over the whole chain the exit depends on dest alone
  function automatic int route_output(input node_id_t dest);
    if (dest < node_id_t'(`DRZ_FIRST_ID)) begin
      return 0;
    end
    if (dest == node_id_t'(`DRZ_FIRST_ID)) begin
      return 1;
    end
    if (dest == node_id_t'(`DRZ_FIRST_ID + 1)) begin
      return 2;
    end
    return 3;
  endfunction

  function automatic string port_name(input int p);
    case (p)
      0: return "top";
      1: return "n0_local";
      2: return "n1_local";
      default: return "bot";
    endcase
  endfunction

  function automatic int pending_flits();
    int n;
    n = 0;
    for (int k = 0; k < NPORT * NPORT; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  function automatic logic all_sent();
    for (int i = 0; i < NPORT; i++) begin
      if (sent_idx[i] < send_q[i].size()) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic compare_flit(input string name, input flit_t exp, input flit_t got, input int b);
    checks[b]++;
    if (got !== exp) begin
      $display("error: %s expected 0x%03h got 0x%03h", name, exp, got);
      fails[b]++;
    end
  endtask

  task automatic compare_hdr(input string name, input flit_hdr_t exp, input flit_hdr_t got,
                             input int b);
    checks[b]++;
    if (got !== exp) begin
      $display("error: %s expected 0x%03h got 0x%03h", name, exp, got);
      fails[b]++;
    end
  endtask

  task automatic compare_id(input string name, input node_id_t exp, input node_id_t got,
                            input int b);
    checks[b]++;
    if (got !== exp) begin
      $display("error: %s expected 0x%01h got 0x%01h", name, exp, got);
      fails[b]++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic got, input int b);
    checks[b]++;
    if (got !== exp) begin
      $display("error: %s expected 0x%0h got 0x%0h", name, exp, got);
      fails[b]++;
    end
  endtask

  // body payload carries the source code and tag so interleaving shows up on its own
  task automatic build_traffic();
    logic [31:0] r;
    int          len;
    int          o;
    flit_t       f;
    flit_hdr_t   h;
    for (int s = 0; s < NPORT; s++) begin
      for (int p = 0; p < NPKT; p++) begin
        draw_random(r);
        len = 1 + int'(r[15:0] % 16'd6);
        h.dest = node_id_t'(r[17:16]);
        h.src = node_id_t'(s);
        h.tag = 2'(p);
        o = route_output(h.dest);
        f.last = (len == 1);
        f.body.hdr = h;
        send_q[s].push_back(f);
        exp_q[o*NPORT+s].push_back(f);
        for (int j = 1; j < len; j++) begin
          draw_random(r);
          f.last = (j == len - 1);
          f.body.raw = {2'(s), 2'(p), r[5:0]};
          send_q[s].push_back(f);
          exp_q[o*NPORT+s].push_back(f);
        end
        flits_sent += len;
        if (o == 1 || o == 2) pkts_exp[0]++;
        if (s == 0 && o == 3) pkts_exp[1]++;
        if (s == 3 && o == 0) pkts_exp[2]++;
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    for (int i = 0; i < NPORT; i++) begin
      if (in_fire[i]) begin
        sent_idx[i]++;
      end
      if (!in_valid[i] || in_fire[i]) begin
        draw_random(r);
        if (sent_idx[i] < send_q[i].size() && r[1:0] != 2'd0) begin
          in_data[i]  <= send_q[i][sent_idx[i]];
          in_valid[i] <= 1'b1;
        end else begin
          in_valid[i] <= 1'b0;
        end
      end
      draw_random(r);
      // ready drops about one cycle in three
      out_ready[i] <= (r % 32'd3) != 32'd0;
    end
  endtask

  task automatic monitor_outputs();
    flit_t got;
    flit_t exp;
    int    s;
    int    b;
    string nm;
    for (int o = 0; o < NPORT; o++) begin
      in_fire[o] = in_valid[o] && in_ready[o];
      if (out_valid[o] && out_ready[o]) begin
        got = out_data[o];
        nm = {port_name(o), "_out_data"};
        b = (o == 1 || o == 2) ? 2 : 3;
        s = in_pkt[o] ? cur_src[o] : int'(got.body.hdr.src);
        if (in_pkt[o]) begin
          compare_id({nm, " source"}, node_id_t'(s), node_id_t'(got.body.raw[9:8]), 4);
          compare_id({nm, " tag"}, node_id_t'(cur_tag[o]), node_id_t'(got.body.raw[7:6]), 4);
        end
        if (s >= NPORT) begin
          $display("header on %s names source %0d, which does not exist", nm, s);
          fails[4]++;
        end else if (exp_q[o*NPORT+s].size() == 0) begin
          $display("flit on %s from source %0d arrived while none was expected", nm, s);
          fails[5]++;
        end else begin
          exp = exp_q[o*NPORT+s].pop_front();
          if (in_pkt[o]) begin
            compare_flit(nm, exp, got, b);
          end else begin
            compare_hdr({nm, " header"}, exp.body.hdr, got.body.hdr, b);
            compare_bit({nm, " last"}, exp.last, got.last, b);
          end
          flits_got++;
        end
        if (!in_pkt[o]) begin
          cur_src[o] = s;
          cur_tag[o] = got.body.hdr.tag;
        end
        if (got.last) begin
          if (o == 1 || o == 2) pkts_got[0]++;
          if (s == 0 && o == 3) pkts_got[1]++;
          if (s == 3 && o == 0) pkts_got[2]++;
        end
        in_pkt[o] = !got.last;
      end
    end
  endtask

  task automatic report_results();
    int total_checks;
    checks[5]++;
    if (pending_flits() != 0) begin
      $display("%0d expected flits never left the chain", pending_flits());
      fails[5]++;
    end
    checks[2]++;
    if (pkts_got[0] != pkts_exp[0]) begin
      $display("local ports delivered %0d packets instead of %0d", pkts_got[0], pkts_exp[0]);
      fails[2]++;
    end
    checks[3]++;
    if (pkts_got[1] != pkts_exp[1] || pkts_got[2] != pkts_exp[2]) begin
      $display("packets crossing the chain went missing");
      fails[3]++;
    end
    $display("behavior 2, local delivery: %0d of %0d packets, %0d checks, %0d errors",
             pkts_got[0], pkts_exp[0], checks[2], fails[2]);
    $display("behavior 3, forwarding: top to bot %0d of %0d, bot to top %0d of %0d, %0d errors",
             pkts_got[1], pkts_exp[1], pkts_got[2], pkts_exp[2], fails[3]);
    $display("behavior 4, wormhole order: %0d checks, %0d errors", checks[4], fails[4]);
    $display("behavior 5, back-pressure and drain: %0d of %0d flits, %0d errors",
             flits_got, flits_sent, fails[5]);
    total_checks = 0;
    total_errors = 0;
    for (int b = 1; b <= 5; b++) begin
      total_checks += checks[b];
      total_errors += fails[b];
    end
    $display("total: %0d checks, %0d errors, %0d cycles", total_checks, total_errors, cycles);
  endtask

  initial begin
    reset     <= 1'b1;
    in_valid  <= '0;
    out_ready <= '0;
    for (int i = 0; i < NPORT; i++) begin
      in_data[i] <= '0;
    end
    rng_state = 32'heb94;
    in_fire = '0;
    in_pkt = '0;
    timed_out = 1'b0;
    build_traffic();

    @(posedge BD_in_clk);
    @(negedge BD_in_clk);
    for (int o = 0; o < NPORT; o++) begin
      compare_bit({port_name(o), "_out_valid"}, 1'b0, out_valid[o], 1);
      compare_bit({port_name(o), "_in_ready"}, 1'b0, in_ready[o], 1);
    end
    @(posedge BD_in_clk);
    reset     <= 1'b0;
    out_ready <= '1;

    // nothing may come out before the first flit goes in
    for (int k = 0; k < 3; k++) begin
      @(posedge BD_in_clk);
      @(negedge BD_in_clk);
      for (int o = 0; o < NPORT; o++) begin
        compare_bit({port_name(o), "_out_valid"}, 1'b0, out_valid[o], 1);
      end
    end
    for (int o = 0; o < NPORT; o++) begin
      compare_bit({port_name(o), "_in_ready"}, 1'b1, in_ready[o], 1);
    end
    $display("behavior 1, reset: %0d checks, %0d errors", checks[1], fails[1]);

    while (!timed_out && quiet < QUIET_CYCLES) begin
      @(posedge BD_in_clk);
      drive_inputs();
      @(negedge BD_in_clk);
      monitor_outputs();
      cycles++;
      if (all_sent()) begin
        drain_cycles++;
        if (pending_flits() == 0) begin
          quiet++;
        end else if (drain_cycles > DRAIN_LIMIT) begin
          $display("timeout: outputs did not drain within %0d cycles", DRAIN_LIMIT);
          timed_out = 1'b1;
        end
      end else if (cycles > SEND_LIMIT) begin
        $display("timeout: inputs did not finish sending within %0d cycles", SEND_LIMIT);
        timed_out = 1'b1;
      end
    end

    report_results();
    if (timed_out || total_errors != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+rtl
rtl/drizzle_pkg.sv
rtl/flit_fifo.sv
rtl/port_input.sv
rtl/port_arbiter.sv
rtl/drizzle_node.sv
rtl/drizzle_chain.sv
bench/drizzle_chain_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= build.f
TOP        ?= drizzle_chain_tb
LINT_TOP   ?= drizzle_chain
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing
LINT_FLAGS ?= --timing
PASS_MSG   ?= Testbench passed

SOURCES := $(wildcard rtl/*.sv rtl/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
